// File: hw/sa_cfg_pkg.sv
`default_nettype none

package sa_cfg_pkg;

    // array geometry
    localparam int PE_SIZE    = 4;
    localparam int DATA_WIDTH = 8;
    localparam int PSUM_WIDTH = 32;

    // one signed operand
    typedef logic signed [DATA_WIDTH-1:0] data_t;

    // one signed partial sum
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

    // operands of one matrix row, element c in byte c
    typedef logic [PE_SIZE*DATA_WIDTH-1:0] row_t;

    // one sum per column, column c in slice c
    typedef logic [PE_SIZE*PSUM_WIDTH-1:0] psum_row_t;

    // one enable per row or column
    typedef logic [PE_SIZE-1:0] en_vec_t;

endpackage

`default_nettype wire

// File: hw/sa_bus_pkg.sv
`default_nettype none

package sa_bus_pkg;

    localparam int ADDR_WIDTH = 8;

    typedef logic [31:0]           word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // register map, byte addresses
    localparam addr_t ADDR_CTRL   = 8'h00;
    localparam addr_t ADDR_STATUS = 8'h04;
    // four rows each, row r at base + 4r
    localparam addr_t ADDR_X_BASE = 8'h10;
    localparam addr_t ADDR_W_BASE = 8'h20;
    // sixteen result words, R[t][c] at base + 16t + 4c
    localparam addr_t ADDR_R_BASE = 8'h40;

    // feeder sequencing
    typedef enum logic [1:0] {
        IDLE,
        PRELOAD,
        STREAM,
        DRAIN
    } feed_state_t;

endpackage

`default_nettype wire

// File: hw/sa_pe.sv
`timescale 1ns/1ps
`default_nettype none

module sa_pe (
    input  logic              clk,
    input  logic              rst_n,
    input  sa_cfg_pkg::data_t ifmap_i,
    input  logic              ifmap_load_i,
    input  sa_cfg_pkg::data_t weight_i,
    input  logic              weight_en_i,
    input  sa_cfg_pkg::psum_t psum_i,
    output sa_cfg_pkg::data_t ifmap_o,
    output sa_cfg_pkg::data_t weight_o,
    output logic              weight_en_o,
    output sa_cfg_pkg::psum_t psum_o,
    output logic              psum_en_o
);

    sa_cfg_pkg::data_t ifmap_q;

    // stationary activation, shifts down only while loading
    always_ff @(posedge clk) begin
        if (ifmap_load_i) begin
            ifmap_q <= ifmap_i;
        end
    end

    assign ifmap_o = ifmap_q;

    // weight moves right, sum moves down
    always_ff @(posedge clk) begin
        weight_o <= weight_i;
        if (weight_en_i) begin
            psum_o <= psum_i + weight_i * ifmap_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_en_o <= 1'b0;
            psum_en_o   <= 1'b0;
        end else begin
            weight_en_o <= weight_en_i;
            psum_en_o   <= weight_en_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/sa_array.sv
`timescale 1ns/1ps
`default_nettype none

module sa_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sa_cfg_pkg::row_t      ifmap_row_i,
    input  logic                  ifmap_preload_i,
    input  sa_cfg_pkg::row_t      weight_col_i,
    input  sa_cfg_pkg::en_vec_t   weight_en_i,
    output sa_cfg_pkg::psum_row_t psum_col_o,
    output sa_cfg_pkg::en_vec_t   psum_en_col_o
);

    typedef logic [$clog2(sa_cfg_pkg::PE_SIZE)-1:0] cnt_t;

    cnt_t load_cnt;
    logic load_en;

    // indexed [row][col]
    sa_cfg_pkg::data_t ifmap_w   [sa_cfg_pkg::PE_SIZE+1][sa_cfg_pkg::PE_SIZE];
    sa_cfg_pkg::data_t weight_w  [sa_cfg_pkg::PE_SIZE][sa_cfg_pkg::PE_SIZE+1];
    logic              wen_w     [sa_cfg_pkg::PE_SIZE][sa_cfg_pkg::PE_SIZE+1];
    sa_cfg_pkg::psum_t psum_w    [sa_cfg_pkg::PE_SIZE+1][sa_cfg_pkg::PE_SIZE];
    logic              psum_en_w [sa_cfg_pkg::PE_SIZE][sa_cfg_pkg::PE_SIZE];

    // stretch the one-cycle preload pulse over PE_SIZE cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_cnt <= '0;
        end else if (ifmap_preload_i) begin
            load_cnt <= cnt_t'(1);
        end else if (load_cnt != '0) begin
            load_cnt <= (load_cnt == cnt_t'(sa_cfg_pkg::PE_SIZE - 1)) ? '0 : load_cnt + 1'b1;
        end
    end

    assign load_en = ifmap_preload_i || (load_cnt != '0);

    for (genvar i = 0; i < sa_cfg_pkg::PE_SIZE; i++) begin : g_edge
        // top edge gets activations and zero sums
        assign ifmap_w[0][i] = ifmap_row_i[sa_cfg_pkg::DATA_WIDTH*i +: sa_cfg_pkg::DATA_WIDTH];
        assign psum_w[0][i]  = '0;
        // left edge gets one weight per row
        assign weight_w[i][0] = weight_col_i[sa_cfg_pkg::DATA_WIDTH*i +: sa_cfg_pkg::DATA_WIDTH];
        assign wen_w[i][0]    = weight_en_i[i];
        // bottom edge
        assign psum_col_o[sa_cfg_pkg::PSUM_WIDTH*i +: sa_cfg_pkg::PSUM_WIDTH] =
            psum_w[sa_cfg_pkg::PE_SIZE][i];
        assign psum_en_col_o[i] = psum_en_w[sa_cfg_pkg::PE_SIZE-1][i];
    end

    for (genvar r = 0; r < sa_cfg_pkg::PE_SIZE; r++) begin : g_row
        for (genvar c = 0; c < sa_cfg_pkg::PE_SIZE; c++) begin : g_col
            sa_pe u_pe (
                .clk          (clk),
                .rst_n        (rst_n),
                .ifmap_i      (ifmap_w[r][c]),
                .ifmap_load_i (load_en),
                .weight_i     (weight_w[r][c]),
                .weight_en_i  (wen_w[r][c]),
                .psum_i       (psum_w[r][c]),
                .ifmap_o      (ifmap_w[r+1][c]),
                .weight_o     (weight_w[r][c+1]),
                .weight_en_o  (wen_w[r][c+1]),
                .psum_o       (psum_w[r+1][c]),
                .psum_en_o    (psum_en_w[r][c])
            );
        end
    end

endmodule

`default_nettype wire

// File: hw/sa_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module sa_feeder (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start_i,
    input  logic                                    full_i,
    output logic [$clog2(sa_cfg_pkg::PE_SIZE)-1:0]  row_idx_o,
    input  sa_cfg_pkg::row_t                        x_row_i,
    input  sa_cfg_pkg::row_t                        w_row_i,
    output sa_cfg_pkg::row_t                        ifmap_row_o,
    output logic                                    ifmap_preload_o,
    output sa_cfg_pkg::row_t                        weight_col_o,
    output sa_cfg_pkg::en_vec_t                     weight_en_o
);

    typedef logic [$clog2(sa_cfg_pkg::PE_SIZE)-1:0] idx_t;

    sa_bus_pkg::feed_state_t state_q;
    idx_t                    cnt_q;
    logic                    last;
    logic                    streaming;

    assign last      = (cnt_q == idx_t'(sa_cfg_pkg::PE_SIZE - 1));
    assign streaming = (state_q == sa_bus_pkg::STREAM);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= sa_bus_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                sa_bus_pkg::IDLE: begin
                    cnt_q <= '0;
                    if (start_i) begin
                        state_q <= sa_bus_pkg::PRELOAD;
                    end
                end
                sa_bus_pkg::PRELOAD, sa_bus_pkg::STREAM: begin
                    cnt_q <= last ? '0 : cnt_q + 1'b1;
                    if (last) begin
                        state_q <= streaming ? sa_bus_pkg::DRAIN : sa_bus_pkg::STREAM;
                    end
                end
                sa_bus_pkg::DRAIN: begin
                    if (full_i) begin
                        state_q <= sa_bus_pkg::IDLE;
                    end
                end
                default: state_q <= sa_bus_pkg::IDLE;
            endcase
        end
    end

    // X goes in bottom row first, W rows in order
    assign row_idx_o       = streaming ? cnt_q : idx_t'(sa_cfg_pkg::PE_SIZE - 1) - cnt_q;
    assign ifmap_row_o     = x_row_i;
    assign ifmap_preload_o = (state_q == sa_bus_pkg::PRELOAD) && (cnt_q == '0);

    // row r sees its weight r cycles after row 0
    for (genvar r = 0; r < sa_cfg_pkg::PE_SIZE; r++) begin : g_skew
        sa_cfg_pkg::data_t w_pipe [r+1];
        logic              en_pipe [r+1];

        always_ff @(posedge clk) begin
            w_pipe[0] <= w_row_i[sa_cfg_pkg::DATA_WIDTH*r +: sa_cfg_pkg::DATA_WIDTH];
            for (int k = 1; k <= r; k++) begin
                w_pipe[k] <= w_pipe[k-1];
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int k = 0; k <= r; k++) begin
                    en_pipe[k] <= 1'b0;
                end
            end else begin
                en_pipe[0] <= streaming;
                for (int k = 1; k <= r; k++) begin
                    en_pipe[k] <= en_pipe[k-1];
                end
            end
        end

        assign weight_col_o[sa_cfg_pkg::DATA_WIDTH*r +: sa_cfg_pkg::DATA_WIDTH] = w_pipe[r];
        assign weight_en_o[r] = en_pipe[r];
    end

endmodule

`default_nettype wire

// File: hw/sa_result_buf.sv
`timescale 1ns/1ps
`default_nettype none

module sa_result_buf (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic                                                        clear_i,
    input  sa_cfg_pkg::psum_row_t                                       psum_col_i,
    input  sa_cfg_pkg::en_vec_t                                         psum_en_col_i,
    input  logic [$clog2(sa_cfg_pkg::PE_SIZE*sa_cfg_pkg::PE_SIZE)-1:0]  rd_idx_i,
    output sa_cfg_pkg::psum_t                                           rd_data_o,
    output logic                                                        full_o
);

    // counts 0 to PE_SIZE, one extra bit for the full value
    typedef logic [$clog2(sa_cfg_pkg::PE_SIZE):0] cnt_t;

    cnt_t                col_cnt [sa_cfg_pkg::PE_SIZE];
    sa_cfg_pkg::en_vec_t col_done;
    sa_cfg_pkg::psum_t   res_mem [sa_cfg_pkg::PE_SIZE*sa_cfg_pkg::PE_SIZE];

    always_comb begin
        for (int c = 0; c < sa_cfg_pkg::PE_SIZE; c++) begin
            col_done[c] = (col_cnt[c] == cnt_t'(sa_cfg_pkg::PE_SIZE));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < sa_cfg_pkg::PE_SIZE; c++) begin
                col_cnt[c] <= '0;
            end
        end else begin
            for (int c = 0; c < sa_cfg_pkg::PE_SIZE; c++) begin
                if (clear_i) begin
                    col_cnt[c] <= '0;
                end else if (psum_en_col_i[c] && !col_done[c]) begin
                    col_cnt[c] <= col_cnt[c] + 1'b1;
                end
            end
        end
    end

    // column c, output t lands in slot 4t + c
    // reads zero until the first run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < sa_cfg_pkg::PE_SIZE*sa_cfg_pkg::PE_SIZE; i++) begin
                res_mem[i] <= '0;
            end
        end else begin
            for (int c = 0; c < sa_cfg_pkg::PE_SIZE; c++) begin
                if (psum_en_col_i[c] && !col_done[c]) begin
                    res_mem[sa_cfg_pkg::PE_SIZE*col_cnt[c] + c] <=
                        psum_col_i[sa_cfg_pkg::PSUM_WIDTH*c +: sa_cfg_pkg::PSUM_WIDTH];
                end
            end
        end
    end

    assign rd_data_o = res_mem[rd_idx_i];
    assign full_o    = &col_done;

endmodule

`default_nettype wire

// File: hw/sa_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sa_wb_regs (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic                                                        cyc_i,
    input  logic                                                        stb_i,
    input  logic                                                        we_i,
    input  sa_bus_pkg::addr_t                                           adr_i,
    input  sa_bus_pkg::word_t                                           dat_i,
    input  logic [$bits(sa_bus_pkg::word_t)/8-1:0]                      sel_i,
    output sa_bus_pkg::word_t                                           dat_o,
    output logic                                                        ack_o,
    input  logic [$clog2(sa_cfg_pkg::PE_SIZE)-1:0]                      row_idx_i,
    output sa_cfg_pkg::row_t                                            x_row_o,
    output sa_cfg_pkg::row_t                                            w_row_o,
    output logic                                                        start_o,
    output logic                                                        clear_o,
    input  logic                                                        full_i,
    output logic [$clog2(sa_cfg_pkg::PE_SIZE*sa_cfg_pkg::PE_SIZE)-1:0]  res_idx_o,
    input  sa_cfg_pkg::psum_t                                           res_data_i
);

    logic                                  access;
    logic                                  hit_ctrl;
    logic                                  hit_status;
    logic                                  hit_x;
    logic                                  hit_w;
    logic                                  hit_res;
    logic [$clog2(sa_cfg_pkg::PE_SIZE)-1:0] op_row;
    logic                                  busy_q;
    logic                                  done_q;
    logic                                  start_q;
    sa_bus_pkg::word_t                     rd_word;
    sa_cfg_pkg::row_t                      x_mem [sa_cfg_pkg::PE_SIZE];
    sa_cfg_pkg::row_t                      w_mem [sa_cfg_pkg::PE_SIZE];

    // new request, not yet acked
    assign access = cyc_i && stb_i && !ack_o;

    assign hit_ctrl   = (adr_i == sa_bus_pkg::ADDR_CTRL);
    assign hit_status = (adr_i == sa_bus_pkg::ADDR_STATUS);
    assign hit_x      = (adr_i[7:4] == sa_bus_pkg::ADDR_X_BASE[7:4]);
    assign hit_w      = (adr_i[7:4] == sa_bus_pkg::ADDR_W_BASE[7:4]);
    assign hit_res    = (adr_i[7:6] == sa_bus_pkg::ADDR_R_BASE[7:6]);
    assign op_row     = adr_i[3:2];
    assign res_idx_o  = adr_i[5:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_o   <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            ack_o   <= access;
            start_q <= 1'b0;
            if (access && we_i && hit_ctrl && sel_i[0] && dat_i[0] && !busy_q) begin
                busy_q  <= 1'b1;
                done_q  <= 1'b0;
                start_q <= 1'b1;
            end else if (busy_q && full_i && !start_q) begin
                // full is stale until the clear pulse has landed
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    assign start_o = start_q;
    assign clear_o = start_q;

    // operands frozen while a run is in flight
    always_ff @(posedge clk) begin
        if (access && we_i && !busy_q) begin
            for (int b = 0; b < $bits(sa_bus_pkg::word_t)/8; b++) begin
                if (sel_i[b] && hit_x) begin
                    x_mem[op_row][8*b +: 8] <= dat_i[8*b +: 8];
                end
                if (sel_i[b] && hit_w) begin
                    w_mem[op_row][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (hit_status) begin
            rd_word[1:0] = {done_q, busy_q};
        end else if (hit_x) begin
            rd_word = x_mem[op_row];
        end else if (hit_w) begin
            rd_word = w_mem[op_row];
        end else if (hit_res) begin
            rd_word = res_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !we_i) begin
            dat_o <= rd_word;
        end
    end

    assign x_row_o = x_mem[row_idx_i];
    assign w_row_o = w_mem[row_idx_i];

endmodule

`default_nettype wire

// File: hw/sa_top.sv
`timescale 1ns/1ps
`default_nettype none

module sa_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   cyc_i,
    input  logic                                   stb_i,
    input  logic                                   we_i,
    input  sa_bus_pkg::addr_t                      adr_i,
    input  sa_bus_pkg::word_t                      dat_i,
    input  logic [$bits(sa_bus_pkg::word_t)/8-1:0] sel_i,
    output sa_bus_pkg::word_t                      dat_o,
    output logic                                   ack_o
);

    logic [$clog2(sa_cfg_pkg::PE_SIZE)-1:0]                      row_idx;
    logic [$clog2(sa_cfg_pkg::PE_SIZE*sa_cfg_pkg::PE_SIZE)-1:0]  res_idx;
    sa_cfg_pkg::row_t      x_row;
    sa_cfg_pkg::row_t      w_row;
    sa_cfg_pkg::row_t      ifmap_row;
    sa_cfg_pkg::row_t      weight_col;
    sa_cfg_pkg::en_vec_t   weight_en;
    sa_cfg_pkg::psum_row_t psum_col;
    sa_cfg_pkg::en_vec_t   psum_en_col;
    sa_cfg_pkg::psum_t     res_data;
    logic                  start;
    logic                  clear;
    logic                  full;
    logic                  preload;

    sa_wb_regs u_regs (
        .clk (clk), .rst_n (rst_n),
        .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i), .adr_i (adr_i),
        .dat_i (dat_i), .sel_i (sel_i), .dat_o (dat_o), .ack_o (ack_o),
        .row_idx_i (row_idx), .x_row_o (x_row), .w_row_o (w_row),
        .start_o (start), .clear_o (clear), .full_i (full),
        .res_idx_o (res_idx), .res_data_i (res_data)
    );

    sa_feeder u_feeder (
        .clk (clk), .rst_n (rst_n), .start_i (start), .full_i (full),
        .row_idx_o (row_idx), .x_row_i (x_row), .w_row_i (w_row),
        .ifmap_row_o (ifmap_row), .ifmap_preload_o (preload),
        .weight_col_o (weight_col), .weight_en_o (weight_en)
    );

    sa_array u_array (
        .clk (clk), .rst_n (rst_n),
        .ifmap_row_i (ifmap_row), .ifmap_preload_i (preload),
        .weight_col_i (weight_col), .weight_en_i (weight_en),
        .psum_col_o (psum_col), .psum_en_col_o (psum_en_col)
    );

    sa_result_buf u_result (
        .clk (clk), .rst_n (rst_n), .clear_i (clear),
        .psum_col_i (psum_col), .psum_en_col_i (psum_en_col),
        .rd_idx_i (res_idx), .rd_data_o (res_data), .full_o (full)
    );

endmodule

`default_nettype wire

// File: sim/sa_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sa_checker (
    input logic clk,
    input logic rst_n,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic busy_i,
    input logic done_i
);

    int fail_cnt = 0;

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack_i |=> !ack_i)
        else begin
            fail_cnt++;
            $error("wishbone ack held longer than one cycle");
        end

    // ack answers a request seen in the cycle before
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        ack_i |-> $past(cyc_i && stb_i))
        else begin
            fail_cnt++;
            $error("wishbone ack without a preceding cyc and stb");
        end

    busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n) !(busy_i && done_i))
        else begin
            fail_cnt++;
            $error("status busy and done set together");
        end

endmodule

bind sa_top sa_checker u_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .cyc_i  (cyc_i),
    .stb_i  (stb_i),
    .ack_i  (ack_o),
    .busy_i (u_regs.busy_q),
    .done_i (u_regs.done_q)
);

`default_nettype wire

// File: sim/sa_tb_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module sa_tb_monitor (
    input  logic              clk,
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  sa_bus_pkg::addr_t adr_i,
    input  logic              ack_i,
    input  sa_bus_pkg::word_t dat_i,
    input  int                test_i,
    input  int                set_i,
    input  logic              check_i,
    input  sa_bus_pkg::word_t status_exp_i,
    output int                err_cnt_o
);

    // per set: X rows, W rows, then R in t-major order
    localparam int SET_WORDS = 24;

    sa_bus_pkg::word_t vec [2*SET_WORDS];
    sa_bus_pkg::word_t pend_exp;
    sa_bus_pkg::addr_t pend_adr;
    logic              pend_chk     = 1'b0;
    int                cur_test     = 0;
    int                test_checks  = 0;
    int                test_errs    = 0;
    int                total_checks = 0;
    int                err_cnt      = 0;

    assign err_cnt_o = err_cnt;

    initial begin
        $readmemh("sim/sa_testdata.hex", vec);
    end

    function automatic sa_bus_pkg::word_t expected(input sa_bus_pkg::addr_t adr, input int set,
                                                   input sa_bus_pkg::word_t status);
        int a;
        int base;
        a    = int'(adr);
        base = (set - 1) * SET_WORDS;
        if (a == int'(sa_bus_pkg::ADDR_STATUS)) begin
            return status;
        end else if (set == 0) begin
            return '0;
        end else if (a >= int'(sa_bus_pkg::ADDR_X_BASE) && a < int'(sa_bus_pkg::ADDR_X_BASE) + 16) begin
            return vec[base + (a - int'(sa_bus_pkg::ADDR_X_BASE)) / 4];
        end else if (a >= int'(sa_bus_pkg::ADDR_W_BASE) && a < int'(sa_bus_pkg::ADDR_W_BASE) + 16) begin
            return vec[base + 4 + (a - int'(sa_bus_pkg::ADDR_W_BASE)) / 4];
        end else if (a >= int'(sa_bus_pkg::ADDR_R_BASE) && a < int'(sa_bus_pkg::ADDR_R_BASE) + 64) begin
            return vec[base + 8 + (a - int'(sa_bus_pkg::ADDR_R_BASE)) / 4];
        end
        return '0;
    endfunction

    // expected word fixed when the request is seen, compared on its ack
    always @(posedge clk) begin
        if (ack_i && pend_chk) begin
            pend_chk = 1'b0;
            test_checks++;
            total_checks++;
            if (dat_i !== pend_exp) begin
                $display("FAIL at %0t: wb_dat_o = 0x%08h, expected 0x%08h (adr 0x%02h)",
                         $time, dat_i, pend_exp, pend_adr);
                test_errs++;
                err_cnt++;
            end
        end
        if (cyc_i && stb_i && !ack_i) begin
            pend_chk = check_i && !we_i;
            pend_exp = expected(adr_i, set_i, status_exp_i);
            pend_adr = adr_i;
        end
    end

    always @(test_i) begin
        if (cur_test != 0) begin
            $display("test %0d: %0d reads checked, %0d mismatches", cur_test, test_checks,
                     test_errs);
        end
        if (test_i == 0 && cur_test != 0) begin
            $display("total: %0d reads checked, %0d mismatches", total_checks, err_cnt);
        end
        cur_test    = test_i;
        test_checks = 0;
        test_errs   = 0;
    end

endmodule

`default_nettype wire

// File: sim/sa_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sa_tb;

    // about 90 scripted accesses plus the status polls of three runs
    localparam int BUS_ACCESSES   = 128;
    localparam int TIMEOUT_CYCLES = BUS_ACCESSES * 10 + 200;
    localparam int SET_WORDS      = 24;
    localparam int MAX_POLLS      = 64;

    logic              clk;
    logic              rst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    sa_bus_pkg::addr_t wb_adr;
    sa_bus_pkg::word_t wb_dat_i;
    logic [3:0]        wb_sel;
    sa_bus_pkg::word_t wb_dat_o;
    logic              wb_ack;

    int                test_id;
    int                set_sel;
    logic              chk;
    sa_bus_pkg::word_t status_exp;
    int                mon_errs;
    int                tb_errs;
    logic [31:0]       rng_state;
    sa_bus_pkg::word_t vec [2*SET_WORDS];

    sa_top u_sa_top (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc_i (wb_cyc),
        .stb_i (wb_stb),
        .we_i  (wb_we),
        .adr_i (wb_adr),
        .dat_i (wb_dat_i),
        .sel_i (wb_sel),
        .dat_o (wb_dat_o),
        .ack_o (wb_ack)
    );

    sa_tb_monitor u_monitor (
        .clk          (clk),
        .cyc_i        (wb_cyc),
        .stb_i        (wb_stb),
        .we_i         (wb_we),
        .adr_i        (wb_adr),
        .ack_i        (wb_ack),
        .dat_i        (wb_dat_o),
        .test_i       (test_id),
        .set_i        (set_sel),
        .check_i      (chk),
        .status_exp_i (status_exp),
        .err_cnt_o    (mon_errs)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic sa_bus_pkg::addr_t row_addr(input sa_bus_pkg::addr_t base, input int r);
        return base + sa_bus_pkg::addr_t'(4 * r);
    endfunction

    task automatic random_gap();
        rng_state = xorshift32(rng_state);
        repeat (rng_state % 4) @(negedge clk);
    endtask

    // inputs change on the falling edge, request held until ack
    task automatic bus_access(input logic we, input sa_bus_pkg::addr_t adr,
                              input sa_bus_pkg::word_t wdata,
                              output sa_bus_pkg::word_t rdata);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        wb_sel   = 4'hf;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic bus_write(input sa_bus_pkg::addr_t adr, input sa_bus_pkg::word_t data);
        sa_bus_pkg::word_t rdata;
        bus_access(1'b1, adr, data, rdata);
    endtask

    task automatic check_read(input sa_bus_pkg::addr_t adr);
        sa_bus_pkg::word_t rdata;
        chk = 1'b1;
        bus_access(1'b0, adr, '0, rdata);
        random_gap();
    endtask

    task automatic garbage_write(input sa_bus_pkg::addr_t adr);
        rng_state = xorshift32(rng_state);
        bus_write(adr, rng_state);
    endtask

    task automatic begin_test(input int id);
        @(negedge clk);
        test_id = id;
    endtask

    task automatic load_operands(input int set);
        for (int r = 0; r < 4; r++) begin
            bus_write(row_addr(sa_bus_pkg::ADDR_X_BASE, r), vec[(set-1)*SET_WORDS + r]);
            bus_write(row_addr(sa_bus_pkg::ADDR_W_BASE, r), vec[(set-1)*SET_WORDS + 4 + r]);
            random_gap();
        end
    endtask

    task automatic read_operands();
        for (int r = 0; r < 4; r++) begin
            check_read(row_addr(sa_bus_pkg::ADDR_X_BASE, r));
            check_read(row_addr(sa_bus_pkg::ADDR_W_BASE, r));
        end
    endtask

    task automatic read_results();
        for (int i = 0; i < 16; i++) begin
            check_read(row_addr(sa_bus_pkg::ADDR_R_BASE, i));
        end
    endtask

    task automatic start_run();
        bus_write(sa_bus_pkg::ADDR_CTRL, 32'h1);
    endtask

    task automatic poll_done();
        sa_bus_pkg::word_t status;
        int                polls;
        chk    = 1'b0;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < MAX_POLLS) begin
            bus_access(1'b0, sa_bus_pkg::ADDR_STATUS, '0, status);
            polls++;
        end
        if (!status[1]) begin
            $display("error: done bit never rose after %0d status polls", polls);
            tb_errs++;
        end
    endtask

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("error: run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_i   = '0;
        wb_sel     = '0;
        test_id    = 0;
        set_sel    = 0;
        chk        = 1'b0;
        status_exp = '0;
        tb_errs    = 0;
        rng_state  = 32'd79;
        $readmemh("sim/sa_testdata.hex", vec);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // quiet after reset
        begin_test(1);
        check_read(sa_bus_pkg::ADDR_STATUS);
        check_read(row_addr(sa_bus_pkg::ADDR_R_BASE, 5));
        check_read(8'h30);

        begin_test(2);
        set_sel = 1;
        load_operands(1);
        read_operands();

        begin_test(3);
        start_run();
        poll_done();
        status_exp = 32'h2;
        check_read(sa_bus_pkg::ADDR_STATUS);
        read_results();
        check_read(8'h30);

        // writes below land while the array is still busy
        begin_test(4);
        set_sel = 2;
        load_operands(2);
        start_run();
        garbage_write(row_addr(sa_bus_pkg::ADDR_X_BASE, 0));
        garbage_write(row_addr(sa_bus_pkg::ADDR_X_BASE, 1));
        garbage_write(row_addr(sa_bus_pkg::ADDR_W_BASE, 0));
        garbage_write(row_addr(sa_bus_pkg::ADDR_W_BASE, 1));
        start_run();
        status_exp = 32'h1;
        check_read(sa_bus_pkg::ADDR_STATUS);
        poll_done();
        read_results();
        read_operands();

        begin_test(5);
        status_exp = 32'h2;
        check_read(sa_bus_pkg::ADDR_STATUS);
        read_results();
        start_run();
        status_exp = 32'h1;
        check_read(sa_bus_pkg::ADDR_STATUS);
        poll_done();

        begin_test(0);
        @(negedge clk);
        if (mon_errs == 0 && tb_errs == 0 && u_sa_top.u_checker.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/sa_testdata.hex
// one 32-bit word per line; per set X rows 0-3 and W rows 0-3 (element c in byte c)
// followed by R[t][c] for t = 0..3, c = 0..3
// set 1
04030201
08070605
FCFDFEFF
03FF0002
00000001
00010100
0300FF02
FE0102FD
00000001
00000002
00000003
00000004
00000004
00000004
00000004
00000004
00000003
FFFFFFFE
FFFFFFFC
00000009
00000002
00000004
00000004
FFFFFFFA
// set 2
000A807F
64FD14CE
01010101
FF40F900
00007F7F
80000080
0105FE03
00FF0000
00002633
FFFFCA6C
00000379
0000319C
FFFFC080
00004380
FFFFDB00
00000080
000001E6
FFFFFE56
00000069
FFFFFF3C
FFFFFFFF
FFFFFFFF
FFFFFFFF
FFFFFFFF

// File: sources.f
hw/sa_cfg_pkg.sv
hw/sa_bus_pkg.sv
hw/sa_pe.sv
hw/sa_array.sv
hw/sa_feeder.sv
hw/sa_result_buf.sv
hw/sa_wb_regs.sv
hw/sa_top.sv
sim/sa_checker.sv
sim/sa_tb_monitor.sv
sim/sa_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := sa_tb
FILELIST   := sources.f
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
